//--- list.f
rtl/line_bus_pkg.sv
rtl/driver_cfg_pkg.sv
rtl/req_queue.sv
rtl/mem_req_encoder.sv
rtl/line_mem_engine.sv
rtl/rsp_tag_checker.sv
rtl/mem_driver_top.sv
testbench/mem_driver_props.sv
testbench/mem_driver_tb.sv

//--- rtl/driver_cfg_pkg.sv
// Memory driver configuration
package driver_cfg_pkg;

    // Entries per request queue
    localparam int QUEUE_DEPTH  = 8;
    // Free slots left when ready drops, covers the registered request in flight
    localparam int QUEUE_MARGIN = 2;
    // Fill needs one more value than depth, so it can report full
    localparam int FILL_W       = $clog2(QUEUE_DEPTH + 1);
    localparam int PTR_W        = $clog2(QUEUE_DEPTH);

    // Tag start values, kept off any power-of-two boundary on purpose
    localparam int READ_TAG_START  = 27;
    localparam int WRITE_TAG_START = 13;

    // Line memory engine states
    typedef enum logic [1:0]
    {
        ENG_IDLE,
        ENG_WRITE_BEAT,
        ENG_READ_BURST
    } engine_state_e;

endpackage

//--- rtl/line_bus_pkg.sv
// Line bus widths and field types
package line_bus_pkg;

    // ====================
    // Field widths
    // ====================

    // One line address is a single word
    localparam int LINE_ADDR_W = 10;
    localparam int LINE_DATA_W = 64;
    // Line count, stored as count minus one (1 to 4 lines)
    localparam int LINE_LEN_W  = 2;
    localparam int TAG_W       = 8;

    // ====================
    // Queue entry layouts
    // ====================

    // Read entry packs {addr, len, tag}, address in the top bits
    localparam int RD_ENTRY_W = LINE_ADDR_W + LINE_LEN_W + TAG_W;
    // Write entry packs {addr, data, tag}, address in the top bits
    localparam int WR_ENTRY_W = LINE_ADDR_W + LINE_DATA_W + TAG_W;

    // Field types used on ports
    typedef logic [LINE_ADDR_W-1:0] line_addr_t;
    typedef logic [LINE_DATA_W-1:0] line_data_t;
    typedef logic [LINE_LEN_W-1:0]  line_len_t;
    typedef logic [TAG_W-1:0]       tag_t;

endpackage

//--- rtl/line_mem_engine.sv
// Line memory engine
`timescale 1ns/1ns

module line_mem_engine
(
    input  logic                                  clk,
    input  logic                                  reset,

    // Queue heads
    input  logic [line_bus_pkg::RD_ENTRY_W-1:0]   rdq_head,
    input  logic                                  rdq_empty,
    input  logic [line_bus_pkg::WR_ENTRY_W-1:0]   wrq_head,
    input  logic                                  wrq_empty,

    output logic                                  rdq_pop,
    output logic                                  wrq_pop,

    // Read beats
    output logic                                  beat_valid,
    output line_bus_pkg::line_data_t              beat_data,
    output line_bus_pkg::tag_t                    beat_tag,
    output logic                                  beat_eop,

    output logic                                  write_ack
);
    import line_bus_pkg::*;
    import driver_cfg_pkg::*;

    localparam int MEM_LINES = 2 ** LINE_ADDR_W;

    line_data_t lines [MEM_LINES];

    engine_state_e state;

    // Unpacked queue heads, tag of a write entry is not needed here
    line_addr_t wr_addr;
    line_data_t wr_data;
    line_addr_t rd_addr;
    line_len_t  rd_len;
    tag_t       rd_tag;

    // Burst in progress
    line_addr_t burst_addr;
    line_len_t  beats_left;
    tag_t       burst_tag;

    assign wr_addr = wrq_head[WR_ENTRY_W-1 -: LINE_ADDR_W];
    assign wr_data = wrq_head[TAG_W +: LINE_DATA_W];
    assign rd_addr = rdq_head[RD_ENTRY_W-1 -: LINE_ADDR_W];
    assign rd_len  = rdq_head[TAG_W +: LINE_LEN_W];
    assign rd_tag  = rdq_head[TAG_W-1:0];

    // Writes win, reads start only on an empty write queue
    assign wrq_pop = !wrq_empty && (state != ENG_READ_BURST);
    assign rdq_pop = wrq_empty && !rdq_empty && (state != ENG_READ_BURST);

    // One ack for every cycle spent retiring a write
    assign write_ack = (state == ENG_WRITE_BEAT);

    // ====================
    // State machine
    // ====================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= ENG_IDLE;
            beats_left <= '0;
            beat_valid <= 1'b0;
            beat_eop   <= 1'b0;
        end
        else
        begin
            beat_valid <= (state == ENG_READ_BURST);
            beat_eop   <= (state == ENG_READ_BURST) && (beats_left == '0);
            if (state == ENG_READ_BURST)
            begin
                beats_left <= beats_left - 1'b1;
                if (beats_left == '0)
                begin
                    state <= ENG_IDLE;
                end
            end
            else if (wrq_pop)
            begin
                state <= ENG_WRITE_BEAT;
            end
            else if (rdq_pop)
            begin
                // Length is already count minus one
                state      <= ENG_READ_BURST;
                beats_left <= rd_len;
            end
            else
            begin
                state <= ENG_IDLE;
            end
        end
    end

    // Burst address steps one line per beat
    always_ff @(posedge clk)
    begin
        if (rdq_pop)
        begin
            burst_addr <= rd_addr;
            burst_tag  <= rd_tag;
        end
        else if (state == ENG_READ_BURST)
        begin
            burst_addr <= burst_addr + 1'b1;
        end
    end

    // ====================
    // Line array
    // ====================

    // No write lands during a burst, so reads see a stable array
    always_ff @(posedge clk)
    begin
        if (wrq_pop)
        begin
            lines[wr_addr] <= wr_data;
        end
        beat_data <= lines[burst_addr];
        beat_tag  <= burst_tag;
    end

endmodule

//--- rtl/mem_driver_top.sv
// Memory driver top level
`timescale 1ns/1ns

module mem_driver_top
(
    input  logic                      clk,
    input  logic                      reset,

    // Read request and response
    input  line_bus_pkg::line_addr_t  read_addr,
    input  line_bus_pkg::line_len_t   read_num_lines,
    input  logic                      read_enable,
    output logic                      read_rdy,
    output line_bus_pkg::line_data_t  read_rsp_data,
    output logic                      read_rsp_valid,
    output logic                      read_tag_error,

    // Write request and ack
    input  line_bus_pkg::line_addr_t  write_addr,
    input  line_bus_pkg::line_data_t  write_data,
    input  logic                      write_sop,
    input  logic                      write_enable,
    output logic                      write_rdy,
    output logic                      write_ack
);
    import line_bus_pkg::*;
    import driver_cfg_pkg::*;

    // Encoder to queues
    logic       rdq_push;
    line_addr_t rdq_addr;
    line_len_t  rdq_len;
    tag_t       rdq_tag;
    logic       wrq_push;
    line_addr_t wrq_addr;
    line_data_t wrq_data;
    tag_t       wrq_tag;

    // Queues to engine
    logic [RD_ENTRY_W-1:0] rdq_head;
    logic [WR_ENTRY_W-1:0] wrq_head;
    logic                  rdq_empty;
    logic                  wrq_empty;
    logic                  rdq_pop;
    logic                  wrq_pop;
    logic [FILL_W-1:0]     rdq_fill;
    logic [FILL_W-1:0]     wrq_fill;

    // Engine to checker
    logic       beat_valid;
    line_data_t beat_data;
    tag_t       beat_tag;
    logic       beat_eop;

    mem_req_encoder encoder
    (
        .clk, .reset,
        .read_addr, .read_num_lines, .read_enable,
        .write_addr, .write_data, .write_sop, .write_enable,
        .rdq_fill, .wrq_fill,
        .read_rdy, .write_rdy,
        .rdq_push, .rdq_addr, .rdq_len, .rdq_tag,
        .wrq_push, .wrq_addr, .wrq_data, .wrq_tag
    );

    // Entries packed with the address on top, as the engine unpacks them
    req_queue #(.ENTRY_W(RD_ENTRY_W)) read_queue
    (
        .clk, .reset,
        .push(rdq_push),
        .push_entry({rdq_addr, rdq_len, rdq_tag}),
        .pop(rdq_pop),
        .head_entry(rdq_head),
        .empty(rdq_empty),
        .fill(rdq_fill)
    );

    req_queue #(.ENTRY_W(WR_ENTRY_W)) write_queue
    (
        .clk, .reset,
        .push(wrq_push),
        .push_entry({wrq_addr, wrq_data, wrq_tag}),
        .pop(wrq_pop),
        .head_entry(wrq_head),
        .empty(wrq_empty),
        .fill(wrq_fill)
    );

    line_mem_engine engine
    (
        .clk, .reset,
        .rdq_head, .rdq_empty, .wrq_head, .wrq_empty,
        .rdq_pop, .wrq_pop,
        .beat_valid, .beat_data, .beat_tag, .beat_eop,
        .write_ack
    );

    rsp_tag_checker tag_checker
    (
        .clk, .reset,
        .beat_valid, .beat_data, .beat_tag, .beat_eop,
        .read_rsp_data, .read_rsp_valid, .read_tag_error
    );

endmodule

//--- rtl/mem_req_encoder.sv
// Client request encoder
`timescale 1ns/1ns

module mem_req_encoder
(
    input  logic                               clk,
    input  logic                               reset,

    // Client read request
    input  line_bus_pkg::line_addr_t           read_addr,
    input  line_bus_pkg::line_len_t            read_num_lines,
    input  logic                               read_enable,

    // Client write request
    input  line_bus_pkg::line_addr_t           write_addr,
    input  line_bus_pkg::line_data_t           write_data,
    input  logic                               write_sop,
    input  logic                               write_enable,

    // Queue fill levels
    input  logic [driver_cfg_pkg::FILL_W-1:0]  rdq_fill,
    input  logic [driver_cfg_pkg::FILL_W-1:0]  wrq_fill,

    output logic                               read_rdy,
    output logic                               write_rdy,

    // Read queue entry
    output logic                               rdq_push,
    output line_bus_pkg::line_addr_t           rdq_addr,
    output line_bus_pkg::line_len_t            rdq_len,
    output line_bus_pkg::tag_t                 rdq_tag,

    // Write queue entry
    output logic                               wrq_push,
    output line_bus_pkg::line_addr_t           wrq_addr,
    output line_bus_pkg::line_data_t           wrq_data,
    output line_bus_pkg::tag_t                 wrq_tag
);
    import line_bus_pkg::*;
    import driver_cfg_pkg::*;

    // Tag counters, one per direction
    tag_t read_tag;
    tag_t write_tag;

    // Ready stays high until the queue is within the margin of full
    assign read_rdy  = (rdq_fill <= FILL_W'(QUEUE_DEPTH - QUEUE_MARGIN));
    assign write_rdy = (wrq_fill <= FILL_W'(QUEUE_DEPTH - QUEUE_MARGIN));

    // ====================
    // Tags
    // ====================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            read_tag  <= tag_t'(READ_TAG_START);
            write_tag <= tag_t'(WRITE_TAG_START);
        end
        else
        begin
            // One read tag per request, whatever its length
            if (read_enable)
            begin
                read_tag <= read_tag + 1'b1;
            end
            // Write tag moves only at the start of a packet
            if (write_enable && write_sop)
            begin
                write_tag <= write_tag + 1'b1;
            end
        end
    end

    // ====================
    // Request registers
    // ====================

    // Push strobes
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rdq_push <= 1'b0;
            wrq_push <= 1'b0;
        end
        else
        begin
            rdq_push <= read_enable;
            wrq_push <= write_enable;
        end
    end

    // Entry fields, qualified by the push strobes
    always_ff @(posedge clk)
    begin
        rdq_addr <= read_addr;
        rdq_len  <= read_num_lines;
        rdq_tag  <= read_tag;
        wrq_addr <= write_addr;
        wrq_data <= write_data;
        wrq_tag  <= write_tag;
    end

endmodule

//--- rtl/req_queue.sv
// Request queue FIFO
`timescale 1ns/1ns

module req_queue
#(
    parameter int ENTRY_W = 20
)
(
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               push,
    input  logic [ENTRY_W-1:0]                 push_entry,
    input  logic                               pop,
    output logic [ENTRY_W-1:0]                 head_entry,
    output logic                               empty,
    output logic [driver_cfg_pkg::FILL_W-1:0]  fill
);
    import driver_cfg_pkg::*;

    // Entry storage
    logic [ENTRY_W-1:0] entries [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;

    // Pop on an empty queue is ignored
    logic pop_ok;

    assign pop_ok     = pop && !empty;
    assign empty      = (fill == '0);
    // Head is read straight from storage
    assign head_entry = entries[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            entries[wr_ptr] <= push_entry;
        end
    end

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Fill holds when push and pop meet
            if (push && !pop_ok)
            begin
                fill <= fill + 1'b1;
            end
            else if (!push && pop_ok)
            begin
                fill <= fill - 1'b1;
            end
        end
    end

endmodule

//--- rtl/rsp_tag_checker.sv
// Read response tag checker
`timescale 1ns/1ns

module rsp_tag_checker
(
    input  logic                      clk,
    input  logic                      reset,

    // Beats from the engine
    input  logic                      beat_valid,
    input  line_bus_pkg::line_data_t  beat_data,
    input  line_bus_pkg::tag_t        beat_tag,
    input  logic                      beat_eop,

    // Client response
    output line_bus_pkg::line_data_t  read_rsp_data,
    output logic                      read_rsp_valid,
    output logic                      read_tag_error
);
    import line_bus_pkg::*;
    import driver_cfg_pkg::*;

    // Tag of the read whose beats are due next
    tag_t expected_tag;
    // Beats seen in the current packet
    line_len_t beat_cnt;

    logic tag_bad;
    logic burst_long;

    assign tag_bad    = beat_valid && (beat_tag != expected_tag);
    // Packet runs past the longest legal burst
    assign burst_long = beat_valid && !beat_eop && (beat_cnt == '1);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            expected_tag   <= tag_t'(READ_TAG_START);
            beat_cnt       <= '0;
            read_rsp_valid <= 1'b0;
            read_tag_error <= 1'b0;
        end
        else
        begin
            read_rsp_valid <= beat_valid;
            if (beat_valid)
            begin
                // Tags return in request order, next one after eop
                if (beat_eop)
                begin
                    expected_tag <= expected_tag + 1'b1;
                    beat_cnt     <= '0;
                end
                else
                begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
            end
            // Sticky until reset
            if (tag_bad || burst_long)
            begin
                read_tag_error <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        read_rsp_data <= beat_data;
    end

endmodule

//--- testbench/mem_driver_props.sv
// Memory driver bound assertions
`timescale 1ns/1ns

module mem_driver_props
(
    input logic clk,
    input logic reset,
    input logic read_enable,
    input logic read_rdy,
    input logic write_enable,
    input logic write_rdy,
    input logic read_rsp_valid,
    input logic write_ack,
    input logic read_tag_error
);
    // Failed assertions so far
    int fail_count;

    // Outputs leave reset idle with both queues ready
    a_reset_values: assert property (@(posedge clk)
        reset |=> !read_rsp_valid && !write_ack && !read_tag_error && read_rdy && write_rdy)
    else
    begin
        fail_count++;
        $error("Outputs not at their reset values after reset");
    end

    // ====================
    // Ready rules
    // ====================

    a_read_enable_rdy: assert property (@(posedge clk) disable iff (reset)
        read_enable |-> read_rdy)
    else
    begin
        fail_count++;
        $error("read_enable raised while read_rdy low");
    end

    a_write_enable_rdy: assert property (@(posedge clk) disable iff (reset)
        write_enable |-> write_rdy)
    else
    begin
        fail_count++;
        $error("write_enable raised while write_rdy low");
    end

    // ====================
    // Tag rule
    // ====================

    a_no_tag_error: assert property (@(posedge clk) disable iff (reset)
        !read_tag_error)
    else
    begin
        fail_count++;
        $error("read_tag_error set");
    end

endmodule

bind mem_driver_top mem_driver_props props
(
    .clk,
    .reset,
    .read_enable,
    .read_rdy,
    .write_enable,
    .write_rdy,
    .read_rsp_valid,
    .write_ack,
    .read_tag_error
);

//--- testbench/mem_driver_tb.sv
// Memory driver testbench
`timescale 1ns/1ns

module mem_driver_tb;
    import line_bus_pkg::*;
    import driver_cfg_pkg::*;

    localparam int PRELOAD_LINES = 64;
    localparam int MIXED_CYCLES  = 300;
    // Four cycles per request slot plus slack for the drain
    localparam int MAX_CYCLES    = (PRELOAD_LINES + MIXED_CYCLES) * 4 + 200;

    logic       clk;
    logic       reset;
    line_addr_t read_addr;
    line_len_t  read_num_lines;
    logic       read_enable;
    logic       read_rdy;
    line_data_t read_rsp_data;
    logic       read_rsp_valid;
    logic       read_tag_error;
    line_addr_t write_addr;
    line_data_t write_data;
    logic       write_sop;
    logic       write_enable;
    logic       write_rdy;
    logic       write_ack;

    // Scoreboard, shadow of the preloaded window and expected beats in order
    line_data_t shadow [64];
    int         pending_reads [64];
    line_data_t exp_data_q [$];
    line_addr_t exp_addr_q [$];

    logic [15:0] lfsr;
    logic [1:0]  wr_hist;
    logic [1:0]  rd_hist;
    logic        read_rdy_seen;
    logic        write_rdy_seen;
    logic        rdq_full_seen;
    int          writes_sent;
    int          acks_seen;
    int          value_errors;
    int          other_errors;
    int          cycles;

    mem_driver_top DUT (.*);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Galois LFSR, taps 16 14 13 11, one step per bit taken
    function automatic logic [63:0] take_bits(input int count);
        logic [63:0] value;
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            if (lfsr[0])
            begin
                lfsr = (lfsr >> 1) ^ 16'hB400;
            end
            else
            begin
                lfsr = lfsr >> 1;
            end
            value = {value[62:0], lfsr[0]};
        end
        return value;
    endfunction

    // One clock of stimulus, requests drop out when not allowed
    task automatic step_requests(input logic want_wr, input line_addr_t wr_addr,
                                 input line_data_t wr_data, input logic want_rd,
                                 input line_addr_t rd_addr, input line_len_t rd_len);
        logic       wr_go;
        logic       rd_go;
        line_addr_t beat_addr;
        @(posedge clk);
        // A request lands in its queue two edges after it is driven, so ready seen
        // before this edge still holds only if nothing went out two edges back
        wr_go = want_wr && write_rdy_seen && !wr_hist[1] && (pending_reads[wr_addr[5:0]] == 0);
        rd_go = want_rd && read_rdy_seen && !rd_hist[1];
        write_enable <= wr_go;
        read_enable  <= rd_go;
        // Write first, a read in the same cycle must see it
        if (wr_go)
        begin
            write_addr <= wr_addr;
            write_data <= wr_data;
            write_sop  <= 1'b1;
            shadow[wr_addr[5:0]] = wr_data;
            writes_sent++;
        end
        if (rd_go)
        begin
            read_addr      <= rd_addr;
            read_num_lines <= rd_len;
            for (int i = 0; i <= int'(rd_len); i++)
            begin
                beat_addr = line_addr_t'(rd_addr + i);
                exp_addr_q.push_back(beat_addr);
                exp_data_q.push_back(shadow[beat_addr[5:0]]);
                pending_reads[beat_addr[5:0]]++;
            end
        end
        wr_hist = {wr_hist[0], wr_go};
        rd_hist = {rd_hist[0], rd_go};
    endtask

    // Compare one returned beat with the head of the expected queue
    task automatic check_beat();
        line_data_t expected;
        line_addr_t addr;
        assert (exp_data_q.size() != 0)
        else
        begin
            other_errors++;
            $display("Read beat at %0t with no read outstanding", $time);
        end
        if (exp_data_q.size() != 0)
        begin
            expected = exp_data_q.pop_front();
            addr     = exp_addr_q.pop_front();
            pending_reads[addr[5:0]]--;
            assert (read_rsp_data == expected)
            else
            begin
                value_errors++;
                $display("Fail %0t read_rsp_data line %0d expected %h actual %h",
                         $time, addr, expected, read_rsp_data);
            end
        end
    endtask

    // ====================
    // Monitor
    // ====================

    // Outputs settle by the falling edge
    always @(negedge clk)
    begin
        read_rdy_seen  = read_rdy;
        write_rdy_seen = write_rdy;
        if (!reset)
        begin
            if (!read_rdy)
            begin
                rdq_full_seen = 1'b1;
            end
            if (write_ack)
            begin
                acks_seen++;
            end
            if (read_rsp_valid)
            begin
                check_beat();
            end
        end
    end

    // Run limit
    initial
    begin
        cycles = 0;
        while (cycles < MAX_CYCLES)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, %0d read beats still due", cycles, exp_data_q.size());
        $display("Test failed");
        $finish;
    end

    // ====================
    // Stimulus
    // ====================

    initial
    begin
        logic       want_wr;
        logic       want_rd;
        line_addr_t wr_addr;
        line_data_t wr_data;
        line_addr_t rd_addr;
        line_len_t  rd_len;
        int         total_errors;
        reset          = 1'b1;
        read_addr      = '0;
        read_num_lines = '0;
        read_enable    = 1'b0;
        write_addr     = '0;
        write_data     = '0;
        write_sop      = 1'b0;
        write_enable   = 1'b0;
        lfsr           = 16'd11418;
        wr_hist        = '0;
        rd_hist        = '0;
        read_rdy_seen  = 1'b0;
        write_rdy_seen = 1'b0;
        rdq_full_seen  = 1'b0;
        writes_sent    = 0;
        acks_seen      = 0;
        value_errors   = 0;
        other_errors   = 0;
        for (int i = 0; i < 64; i++)
        begin
            pending_reads[i] = 0;
        end
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        // Fill the whole read window so no read sees an unwritten line
        while (writes_sent < PRELOAD_LINES)
        begin
            step_requests(1'b1, line_addr_t'(writes_sent), take_bits(64), 1'b0, '0, '0);
        end

        // Mixed traffic, reads dense enough to fill the read queue
        for (int n = 0; n < MIXED_CYCLES; n++)
        begin
            want_wr = (take_bits(2) == 64'd0);
            wr_addr = line_addr_t'(take_bits(5));
            wr_data = take_bits(64);
            want_rd = (take_bits(2) != 64'd0);
            rd_addr = line_addr_t'(take_bits(5));
            rd_len  = line_len_t'(take_bits(2));
            step_requests(want_wr, wr_addr, wr_data, want_rd, rd_addr, rd_len);
        end
        @(posedge clk);
        read_enable  <= 1'b0;
        write_enable <= 1'b0;

        // Drain, then idle a while to catch stray beats or acks
        while (exp_data_q.size() != 0 || acks_seen != writes_sent)
        begin
            @(posedge clk);
        end
        repeat (20) @(posedge clk);

        assert (acks_seen == writes_sent)
        else
        begin
            value_errors++;
            $display("Fail %0t write_ack count expected %0d actual %0d",
                     $time, writes_sent, acks_seen);
        end
        assert (rdq_full_seen)
        else
        begin
            other_errors++;
            $display("Read queue never filled up to the ready margin");
        end

        total_errors = value_errors + other_errors + DUT.props.fail_count;
        $display("Errors: %0d value, %0d other, %0d assertion",
                 value_errors, other_errors, DUT.props.fail_count);
        if (total_errors == 0)
        begin
            $display("Test passed");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
